// File: include/cp0_macros.svh
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// register map on the AXI4-Lite port, one word each
`define CP0_ADDR_STATUS        32'h0000_0000
`define CP0_ADDR_CAUSE         32'h0000_0004
`define CP0_ADDR_EPC           32'h0000_0008
`define CP0_ADDR_EBASE         32'h0000_000C
`define CP0_ADDR_BADVADDR      32'h0000_0010

`define STATUS_IE_BIT          0
`define STATUS_EXL_BIT         1
`define STATUS_BEV_BIT         22
`define STATUS_IM_MSB          15
`define STATUS_IM_LSB          8
`define CAUSE_IP_MSB           15
`define CAUSE_IP_LSB           8

// handler vectors
`define BEV_VECTOR_BASE        32'hBFC0_0200
`define GENERAL_VECTOR_OFFSET  32'h0000_0180

// Cause.ExcCode values
`define EXC_CODE_INT           5'h00
`define EXC_CODE_MOD           5'h01
`define EXC_CODE_TLBL          5'h02
`define EXC_CODE_TLBS          5'h03
`define EXC_CODE_ADEL          5'h04
`define EXC_CODE_ADES          5'h05
`define EXC_CODE_SYS           5'h08
`define EXC_CODE_BP            5'h09
`define EXC_CODE_RI            5'h0A
`define EXC_CODE_OV            5'h0C
`define EXC_CODE_ERET          5'h1E   // internal marker
`define EXC_CODE_NONE          5'h1F   // internal marker

`define AXI_RESP_OKAY          2'b00
`define AXI_RESP_SLVERR        2'b10

`endif

// File: hdl/cp0_pkg.sv
package cp0_pkg;

   // Status register, MSB first
   typedef struct packed {
      logic [2:0] rsvd_31_29;
      logic       cu0;
      logic [4:0] rsvd_27_23;
      logic       bev;         // bootstrap vectors
      logic [5:0] rsvd_21_16;
      logic [7:0] im;          // interrupt mask
      logic [5:0] rsvd_7_2;
      logic       exl;
      logic       ie;
   } status_t;

   // Cause register, MSB first
   typedef struct packed {
      logic        bd;
      logic [14:0] rsvd_30_16;
      logic [7:0]  ip;          // ip[7:2] hw, ip[1:0] sw
      logic        rsvd_7;
      logic [4:0]  exc_code;
      logic [1:0]  rsvd_1_0;
   } cause_t;

   // one cp0 data word seen as Status, as Cause or raw
   typedef union packed {
      status_t     status;
      cause_t      cause;
      logic [31:0] raw;
   } cp0_word_u;

endpackage

// File: hdl/exc_pkg.sv
`include "cp0_macros.svh"

package exc_pkg;

   typedef enum logic [4:0] {
      EXC_INT  = `EXC_CODE_INT,
      EXC_MOD  = `EXC_CODE_MOD,
      EXC_TLBL = `EXC_CODE_TLBL,
      EXC_TLBS = `EXC_CODE_TLBS,
      EXC_ADEL = `EXC_CODE_ADEL,
      EXC_ADES = `EXC_CODE_ADES,
      EXC_SYS  = `EXC_CODE_SYS,
      EXC_BP   = `EXC_CODE_BP,
      EXC_RI   = `EXC_CODE_RI,
      EXC_OV   = `EXC_CODE_OV,
      EXC_ERET = `EXC_CODE_ERET,
      EXC_NONE = `EXC_CODE_NONE
   } exc_code_e;

   // memory-stage fault flags
   typedef struct packed {
      logic ri;
      logic brk;
      logic syscall;
      logic overflow;
      logic addr_err_load;
      logic addr_err_store;
      logic pc_err;
      logic eret;
      logic inst_tlb_refill;
      logic inst_tlb_invalid;
      logic data_tlb_refill;
      logic data_tlb_invalid;
      logic data_tlb_modify;
   } fault_flags_t;

endpackage

// File: hdl/exc_prioritizer.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module exc_prioritizer import exc_pkg::*; (
   input  logic        ri,
   input  logic        brk,
   input  logic        syscall,
   input  logic        overflow,
   input  logic        addr_err_load,
   input  logic        addr_err_store,
   input  logic        pc_err,
   input  logic        eret,
   input  logic        mem_read_en,
   input  logic        mem_write_en,
   input  logic        inst_tlb_refill,
   input  logic        inst_tlb_invalid,
   input  logic        data_tlb_refill,
   input  logic        data_tlb_invalid,
   input  logic        data_tlb_modify,
   input  logic [31:0] pc,
   input  logic [31:0] alu_out,
   input  logic [31:0] cp0_status,
   input  logic [31:0] cp0_cause,
   input  logic [31:0] cp0_epc,
   input  logic [31:0] cp0_ebase,
   output exc_code_e   except_type,
   output logic        flush,
   output logic [31:0] exc_pc,
   output logic [31:0] bad_vaddr
);

   fault_flags_t flags;
   logic         int_pending;
   logic         tlbl;
   logic         tlbs;
   logic         refill;
   logic [31:0]  vec_base;
   logic [31:0]  vec_offset;

   assign flags = '{ri: ri, brk: brk, syscall: syscall, overflow: overflow,
                    addr_err_load: addr_err_load, addr_err_store: addr_err_store,
                    pc_err: pc_err, eret: eret,
                    inst_tlb_refill: inst_tlb_refill, inst_tlb_invalid: inst_tlb_invalid,
                    data_tlb_refill: data_tlb_refill, data_tlb_invalid: data_tlb_invalid,
                    data_tlb_modify: data_tlb_modify};

   // enabled, not already in a handler, some unmasked ip
   assign int_pending = cp0_status[`STATUS_IE_BIT] & ~cp0_status[`STATUS_EXL_BIT] &
                        (|(cp0_status[`STATUS_IM_MSB:`STATUS_IM_LSB] &
                           cp0_cause[`CAUSE_IP_MSB:`CAUSE_IP_LSB]));

   assign tlbl = flags.inst_tlb_refill | flags.inst_tlb_invalid |
                 (mem_read_en & (flags.data_tlb_refill | flags.data_tlb_invalid));
   assign tlbs = mem_write_en & (flags.data_tlb_refill | flags.data_tlb_invalid);

   always_comb begin
      if (int_pending)                              except_type = EXC_INT;
      else if (flags.addr_err_load | flags.pc_err)  except_type = EXC_ADEL;
      else if (flags.data_tlb_modify)               except_type = EXC_MOD;
      else if (tlbl)                                except_type = EXC_TLBL;
      else if (tlbs)                                except_type = EXC_TLBS;
      else if (flags.ri)                            except_type = EXC_RI;
      else if (flags.syscall)                       except_type = EXC_SYS;
      else if (flags.brk)                           except_type = EXC_BP;
      else if (flags.addr_err_store)                except_type = EXC_ADES;
      else if (flags.overflow)                      except_type = EXC_OV;
      else if (flags.eret)                          except_type = EXC_ERET;
      else                                          except_type = EXC_NONE;
   end

   assign flush = (except_type != EXC_NONE);

   // refill only takes offset 0 when the tlb exception is the one taken
   assign refill = ((except_type == EXC_TLBL) | (except_type == EXC_TLBS)) &
                   (flags.inst_tlb_refill |
                    ((mem_read_en | mem_write_en) & flags.data_tlb_refill));

   assign vec_base   = cp0_status[`STATUS_BEV_BIT] ? `BEV_VECTOR_BASE : cp0_ebase;
   assign vec_offset = refill ? 32'h0 : `GENERAL_VECTOR_OFFSET;
   assign exc_pc     = (except_type == EXC_ERET) ? cp0_epc : vec_base + vec_offset;

   // fetch side faults report the pc, data side the computed address
   assign bad_vaddr = (flags.pc_err | flags.inst_tlb_refill | flags.inst_tlb_invalid) ?
                      pc : alu_out;

endmodule

// File: hdl/cp0_regs.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0_regs import cp0_pkg::*, exc_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  exc_code_e   except_type,
   input  logic        flush,
   input  logic [31:0] pc,
   input  logic [31:0] bad_vaddr,
   input  logic [5:0]  hw_int,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   output logic [31:0] cp0_status,
   output logic [31:0] cp0_cause,
   output logic [31:0] cp0_epc,
   output logic [31:0] cp0_ebase
);

   localparam status_t STATUS_RST = '{bev: 1'b1, default: '0};

   status_t     status_q;
   status_t     status_d;
   cause_t      cause_q;
   cause_t      cause_d;
   logic [31:0] epc_q;
   logic [31:0] ebase_q;
   logic [31:0] badvaddr_q;
   logic        wr_en;
   logic        rd_en;
   logic        wr_status;
   logic        wr_cause;
   logic        wr_epc;
   logic        wr_ebase;
   logic        wr_mapped;
   logic [31:0] wr_old;
   logic [31:0] wr_mask;
   cp0_word_u   wr_word;
   logic        commit_exc;
   logic        commit_eret;
   logic        bad_addr_exc;
   logic [31:0] rd_data;
   logic        rd_mapped;

   assign wr_en   = awvalid & wvalid & ~bvalid;
   assign awready = wr_en;
   assign wready  = wr_en;
   assign rd_en   = arvalid & ~rvalid;
   assign arready = rd_en;

   assign wr_mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

   always_comb begin
      wr_status = 1'b0;
      wr_cause  = 1'b0;
      wr_epc    = 1'b0;
      wr_ebase  = 1'b0;
      wr_mapped = 1'b1;
      wr_old    = '0;
      case (awaddr)
         `CP0_ADDR_STATUS: begin
            wr_status = wr_en;
            wr_old    = status_q;
         end
         `CP0_ADDR_CAUSE: begin
            wr_cause = wr_en;
            wr_old   = cause_q;
         end
         `CP0_ADDR_EPC: begin
            wr_epc = wr_en;
            wr_old = epc_q;
         end
         `CP0_ADDR_EBASE: begin
            wr_ebase = wr_en;
            wr_old   = ebase_q;
         end
         `CP0_ADDR_BADVADDR: wr_mapped = 1'b1;   // read-only, write dropped
         default:            wr_mapped = 1'b0;
      endcase
      wr_word.raw = (wr_old & ~wr_mask) | (wdata & wr_mask);
   end

   assign commit_exc   = flush & (except_type != EXC_ERET);
   assign commit_eret  = flush & (except_type == EXC_ERET);
   assign bad_addr_exc = commit_exc &
                         (except_type inside {EXC_ADEL, EXC_ADES, EXC_MOD, EXC_TLBL, EXC_TLBS});

   always_comb begin
      status_d = status_q;
      if (wr_status) begin
         status_d.cu0 = wr_word.status.cu0;
         status_d.bev = wr_word.status.bev;
         status_d.im  = wr_word.status.im;
         status_d.exl = wr_word.status.exl;
         status_d.ie  = wr_word.status.ie;
      end
      if (commit_exc)
         status_d.exl = 1'b1;   // commit beats sw write
      else if (commit_eret)
         status_d.exl = 1'b0;
   end

   always_comb begin
      cause_d         = cause_q;
      cause_d.ip[7:2] = hw_int;
      if (wr_cause)
         cause_d.ip[1:0] = wr_word.cause.ip[1:0];   // sw interrupts only
      if (commit_exc)
         cause_d.exc_code = except_type;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status_q   <= STATUS_RST;
         cause_q    <= '0;
         epc_q      <= '0;
         ebase_q    <= '0;
         badvaddr_q <= '0;
      end else begin
         status_q <= status_d;
         cause_q  <= cause_d;
         if (commit_exc)
            epc_q <= pc;
         else if (wr_epc)
            epc_q <= wr_word.raw;
         if (wr_ebase)
            ebase_q <= wr_word.raw;
         if (bad_addr_exc)
            badvaddr_q <= bad_vaddr;
      end
   end

   // write response
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bvalid <= 1'b0;
         bresp  <= `AXI_RESP_OKAY;
      end else if (wr_en) begin
         bvalid <= 1'b1;
         bresp  <= wr_mapped ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   always_comb begin
      rd_mapped = 1'b1;
      case (araddr)
         `CP0_ADDR_STATUS:   rd_data = status_q;
         `CP0_ADDR_CAUSE:    rd_data = cause_q;
         `CP0_ADDR_EPC:      rd_data = epc_q;
         `CP0_ADDR_EBASE:    rd_data = ebase_q;
         `CP0_ADDR_BADVADDR: rd_data = badvaddr_q;
         default: begin
            rd_data   = '0;
            rd_mapped = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid <= 1'b0;
         rresp  <= `AXI_RESP_OKAY;
      end else if (rd_en) begin
         rvalid <= 1'b1;
         rresp  <= rd_mapped ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en)
         rdata <= rd_data;
   end

   assign cp0_status = status_q;
   assign cp0_cause  = cause_q;
   assign cp0_epc    = epc_q;
   assign cp0_ebase  = ebase_q;

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp));
   a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata));
   // exl only rises from a flushed exception or a direct sw write
   a_exl_source: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(status_q.exl) |-> $past(commit_exc) || $past(wr_status && wr_word.status.exl));

endmodule

// File: hdl/exc_unit.sv
`timescale 1ns/1ps

module exc_unit import exc_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        ri,
   input  logic        brk,
   input  logic        syscall,
   input  logic        overflow,
   input  logic        addr_err_load,
   input  logic        addr_err_store,
   input  logic        pc_err,
   input  logic        eret,
   input  logic        mem_read_en,
   input  logic        mem_write_en,
   input  logic        inst_tlb_refill,
   input  logic        inst_tlb_invalid,
   input  logic        data_tlb_refill,
   input  logic        data_tlb_invalid,
   input  logic        data_tlb_modify,
   input  logic [31:0] pc,
   input  logic [31:0] alu_out,
   input  logic [5:0]  hw_int,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   output exc_code_e   except_type,
   output logic        flush,
   output logic [31:0] exc_pc,
   output logic [31:0] bad_vaddr
);

   logic [31:0] cp0_status;
   logic [31:0] cp0_cause;
   logic [31:0] cp0_epc;
   logic [31:0] cp0_ebase;

   exc_prioritizer u_exc_prioritizer (
      .ri               (ri),
      .brk              (brk),
      .syscall          (syscall),
      .overflow         (overflow),
      .addr_err_load    (addr_err_load),
      .addr_err_store   (addr_err_store),
      .pc_err           (pc_err),
      .eret             (eret),
      .mem_read_en      (mem_read_en),
      .mem_write_en     (mem_write_en),
      .inst_tlb_refill  (inst_tlb_refill),
      .inst_tlb_invalid (inst_tlb_invalid),
      .data_tlb_refill  (data_tlb_refill),
      .data_tlb_invalid (data_tlb_invalid),
      .data_tlb_modify  (data_tlb_modify),
      .pc               (pc),
      .alu_out          (alu_out),
      .cp0_status       (cp0_status),
      .cp0_cause        (cp0_cause),
      .cp0_epc          (cp0_epc),
      .cp0_ebase        (cp0_ebase),
      .except_type      (except_type),
      .flush            (flush),
      .exc_pc           (exc_pc),
      .bad_vaddr        (bad_vaddr)
   );

   cp0_regs u_cp0_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .except_type (except_type),
      .flush       (flush),
      .pc          (pc),
      .bad_vaddr   (bad_vaddr),   // committed with the flush
      .hw_int      (hw_int),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .cp0_status  (cp0_status),
      .cp0_cause   (cp0_cause),
      .cp0_epc     (cp0_epc),
      .cp0_ebase   (cp0_ebase)
   );

endmodule

// File: bench/exc_unit_tb.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module exc_unit_tb import cp0_pkg::*, exc_pkg::*;;

   // fault flag bits, same order as fault_flags_t
   localparam logic [12:0] F_RI   = 13'h1000;
   localparam logic [12:0] F_BRK  = 13'h0800;
   localparam logic [12:0] F_SYS  = 13'h0400;
   localparam logic [12:0] F_OV   = 13'h0200;
   localparam logic [12:0] F_AEL  = 13'h0100;
   localparam logic [12:0] F_AES  = 13'h0080;
   localparam logic [12:0] F_PCE  = 13'h0040;
   localparam logic [12:0] F_ERET = 13'h0020;
   localparam logic [12:0] F_ITR  = 13'h0010;
   localparam logic [12:0] F_DTR  = 13'h0004;
   localparam logic [12:0] F_DTI  = 13'h0002;
   localparam logic [12:0] F_DTM  = 13'h0001;

   localparam logic [31:0] ST_IE  = 32'd1 << `STATUS_IE_BIT;
   localparam logic [31:0] ST_EXL = 32'd1 << `STATUS_EXL_BIT;
   localparam logic [31:0] ST_BEV = 32'd1 << `STATUS_BEV_BIT;

   typedef struct {
      fault_flags_t f;
      logic         rd;
      logic         wr;
      logic [31:0]  status;
      logic [1:0]   sw_ip;
      logic [5:0]   hw;
      exc_code_e    exp;
   } row_t;

   logic clk = 1'b0;
   logic arst_n = 1'b0;
   logic ri = 1'b0, brk = 1'b0, syscall = 1'b0, overflow = 1'b0;
   logic addr_err_load = 1'b0, addr_err_store = 1'b0, pc_err = 1'b0, eret = 1'b0;
   logic mem_read_en = 1'b0, mem_write_en = 1'b0;
   logic inst_tlb_refill = 1'b0, inst_tlb_invalid = 1'b0;
   logic data_tlb_refill = 1'b0, data_tlb_invalid = 1'b0, data_tlb_modify = 1'b0;
   logic [31:0] pc = '0, alu_out = '0;
   logic [5:0]  hw_int = '0;
   logic [31:0] awaddr = '0, wdata = '0, araddr = '0;
   logic [3:0]  wstrb = '0;
   logic        awvalid = 1'b0, wvalid = 1'b0, bready = 1'b0, arvalid = 1'b0, rready = 1'b0;
   logic        awready, wready, bvalid, arready, rvalid, flush;
   logic [1:0]  bresp, rresp;
   logic [31:0] rdata, exc_pc, bad_vaddr;
   exc_code_e   except_type;

   row_t        rows[$];
   logic        rows_ready = 1'b0;
   logic [31:0] lfsr_state = 32'hffc18b1b;
   logic [31:0] ebase_model;
   logic [31:0] epc_model;
   logic [31:0] bad_model = '0;

   exc_unit u_exc_unit (.*);

   always #5 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR: time %0t: %s got %h expected %h", $time, what, got, exp);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   // tasks start and end 1 ns after a rising edge
   task automatic axi_write_start(input logic [31:0] addr, input logic [31:0] data);
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge clk);
      while (!awready) @(negedge clk);
      check("wready", {31'b0, wready}, 32'd1);   // pulses with awready
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      axi_write_start(addr, data);
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      resp = bresp;
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   task automatic drive_flags(input fault_flags_t f, input logic rd, input logic wr);
      ri               = f.ri;
      brk              = f.brk;
      syscall          = f.syscall;
      overflow         = f.overflow;
      addr_err_load    = f.addr_err_load;
      addr_err_store   = f.addr_err_store;
      pc_err           = f.pc_err;
      eret             = f.eret;
      inst_tlb_refill  = f.inst_tlb_refill;
      inst_tlb_invalid = f.inst_tlb_invalid;
      data_tlb_refill  = f.data_tlb_refill;
      data_tlb_invalid = f.data_tlb_invalid;
      data_tlb_modify  = f.data_tlb_modify;
      mem_read_en      = rd;
      mem_write_en     = wr;
   endtask

   task automatic add_row(input logic [12:0] f, input logic rd, input logic wr,
                          input logic [31:0] st, input logic [1:0] sw,
                          input logic [5:0] hw, input exc_code_e exp);
      row_t r;
      r.f      = fault_flags_t'(f);
      r.rd     = rd;
      r.wr     = wr;
      r.status = st;
      r.sw_ip  = sw;
      r.hw     = hw;
      r.exp    = exp;
      rows.push_back(r);
   endtask

   task automatic run_row(input row_t r, input int idx);
      logic [31:0] pcv, aluv, base, exp_pc, exp_bad, data;
      logic [1:0]  resp;
      logic        refill;
      cp0_word_u   w;
      pcv  = rand_bits(32);
      aluv = rand_bits(32);
      axi_write(`CP0_ADDR_STATUS, r.status & ~ST_IE, resp);   // no interrupt during setup
      w.raw = '0;
      w.cause.ip[1:0] = r.sw_ip;
      axi_write(`CP0_ADDR_CAUSE, w.raw, resp);
      hw_int  = r.hw;
      pc      = pcv;
      alu_out = aluv;
      repeat (2) @(posedge clk);
      #1;
      axi_write_start(`CP0_ADDR_STATUS, r.status);
      drive_flags(r.f, r.rd, r.wr);
      @(negedge clk);
      $display("row %0d: except_type %0h", idx, except_type);
      check("except_type", {27'b0, except_type}, {27'b0, r.exp});
      check("flush", {31'b0, flush}, {31'b0, r.exp != EXC_NONE});
      // a taken tlb exception caused by a refill uses offset 0
      refill = (r.exp == EXC_TLBL || r.exp == EXC_TLBS) &&
               (r.f.inst_tlb_refill || r.f.data_tlb_refill);
      base   = r.status[`STATUS_BEV_BIT] ? `BEV_VECTOR_BASE : ebase_model;
      exp_pc = (r.exp == EXC_ERET) ? epc_model :
               base + (refill ? 32'h0 : `GENERAL_VECTOR_OFFSET);
      if (r.exp != EXC_NONE)
         check("exc_pc", exc_pc, exp_pc);
      exp_bad = (r.f.pc_err || r.f.inst_tlb_refill || r.f.inst_tlb_invalid) ? pcv : aluv;
      check("bad_vaddr", bad_vaddr, exp_bad);
      resp = bresp;
      @(posedge clk);
      #1;
      drive_flags('0, 1'b0, 1'b0);
      bready = 1'b0;
      check("status bresp", {30'b0, resp}, {30'b0, `AXI_RESP_OKAY});
      if (r.exp == EXC_NONE)
         return;
      axi_read(`CP0_ADDR_STATUS, data, resp);
      w.raw = data;
      check("status exl", {31'b0, w.status.exl}, {31'b0, r.exp != EXC_ERET});
      if (r.exp == EXC_ERET)
         return;
      epc_model = pcv;
      if (r.exp inside {EXC_ADEL, EXC_ADES, EXC_MOD, EXC_TLBL, EXC_TLBS})
         bad_model = exp_bad;
      axi_read(`CP0_ADDR_EPC, data, resp);
      check("epc", data, epc_model);
      axi_read(`CP0_ADDR_CAUSE, data, resp);
      w.raw = data;
      check("cause exc_code", {27'b0, w.cause.exc_code}, {27'b0, r.exp});
      axi_read(`CP0_ADDR_BADVADDR, data, resp);
      check("badvaddr", data, bad_model);
   endtask

   task automatic reg_access;
      logic [31:0] data, v;
      logic [1:0]  resp;
      axi_read(`CP0_ADDR_STATUS, data, resp);
      check("status after reset", data, ST_BEV);
      axi_write(`CP0_ADDR_STATUS, 32'hFFFF_FFFF, resp);
      axi_read(`CP0_ADDR_STATUS, data, resp);
      check("status writable bits", data, 32'h1040_FF03);
      axi_write(`CP0_ADDR_CAUSE, 32'hFFFF_FFFF, resp);
      axi_read(`CP0_ADDR_CAUSE, data, resp);
      check("cause sw ip only", data, 32'h0000_0300);
      axi_write(`CP0_ADDR_CAUSE, 32'h0, resp);
      axi_write(`CP0_ADDR_STATUS, ST_BEV, resp);
      v = rand_bits(32);
      axi_write(`CP0_ADDR_EPC, v, resp);
      axi_read(`CP0_ADDR_EPC, data, resp);
      check("epc readback", data, v);
      epc_model   = v;
      ebase_model = rand_bits(32);
      axi_write(`CP0_ADDR_EBASE, ebase_model, resp);
      axi_read(`CP0_ADDR_EBASE, data, resp);
      check("ebase readback", data, ebase_model);
      axi_write(`CP0_ADDR_BADVADDR, 32'hDEAD_BEEF, resp);
      check("badvaddr write bresp", {30'b0, resp}, {30'b0, `AXI_RESP_OKAY});
      axi_read(`CP0_ADDR_BADVADDR, data, resp);
      check("badvaddr read-only", data, 32'h0);
      axi_write(32'h0000_0020, 32'h1234_5678, resp);
      check("unmapped bresp", {30'b0, resp}, {30'b0, `AXI_RESP_SLVERR});
      axi_read(32'h0000_0020, data, resp);
      check("unmapped rresp", {30'b0, resp}, {30'b0, `AXI_RESP_SLVERR});
   endtask

   initial begin
      wait (rows_ready);
      #(rows.size() * 50 * 10 + 2000);
      $display("watchdog expired before the tests completed");
      $display("Test failures found");
      $fatal(1);
   end

   initial begin
      add_row(F_RI | F_SYS | F_OV,    0, 0, ST_BEV, 2'b00, 6'h00, EXC_RI);
      add_row(F_SYS | F_BRK | F_AES,  0, 1, 32'h0,  2'b00, 6'h00, EXC_SYS);
      add_row(F_BRK | F_AES | F_OV,   0, 1, ST_BEV, 2'b00, 6'h00, EXC_BP);
      add_row(F_AES | F_OV,           0, 1, 32'h0,  2'b00, 6'h00, EXC_ADES);
      add_row(F_OV,                   0, 0, ST_BEV, 2'b00, 6'h00, EXC_OV);
      add_row(F_AEL | F_DTM | F_RI,   1, 0, 32'h0,  2'b00, 6'h00, EXC_ADEL);
      add_row(F_PCE,                  0, 0, ST_BEV, 2'b00, 6'h00, EXC_ADEL);
      add_row(F_DTM | F_DTR,          1, 0, 32'h0,  2'b00, 6'h00, EXC_MOD);
      add_row(F_ITR | F_RI,           0, 0, 32'h0,  2'b00, 6'h00, EXC_TLBL);
      add_row(F_DTI,                  1, 0, 32'h0,  2'b00, 6'h00, EXC_TLBL);
      add_row(F_DTR,                  0, 1, ST_BEV, 2'b00, 6'h00, EXC_TLBS);
      add_row(F_DTR,                  0, 0, ST_BEV, 2'b00, 6'h00, EXC_NONE);
      add_row(F_OV, 0, 0, ST_IE | 32'h0000_0100,          2'b01, 6'h00, EXC_INT);
      add_row('0,   0, 0, 32'h0000_0100,                  2'b01, 6'h00, EXC_NONE);
      add_row('0,   0, 0, ST_IE | ST_EXL | 32'h0000_0100, 2'b01, 6'h00, EXC_NONE);
      add_row('0,   0, 0, ST_IE | 32'h0000_8000,          2'b00, 6'h20, EXC_INT);
      add_row('0,   0, 0, ST_IE | 32'h0000_0400,          2'b00, 6'h20, EXC_NONE);
      add_row(F_ERET,        0, 0, ST_EXL,          2'b00, 6'h00, EXC_ERET);
      add_row(F_ERET | F_OV, 0, 0, ST_EXL | ST_BEV, 2'b00, 6'h00, EXC_OV);
      add_row(F_ERET,        0, 0, ST_EXL | ST_BEV, 2'b00, 6'h00, EXC_ERET);
      rows_ready = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;
      reg_access();
      foreach (rows[i])
         run_row(rows[i], i);
      $display("All tests passed!");
      $finish;
   end

endmodule

// File: list.f
+incdir+include
hdl/cp0_pkg.sv
hdl/exc_pkg.sv
hdl/exc_prioritizer.sv
hdl/cp0_regs.sv
hdl/exc_unit.sv
bench/exc_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exc_unit_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir

SOURCES := $(wildcard hdl/*.sv) $(wildcard bench/*.sv) $(wildcard include/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
